// ==== design/bridgePkg.sv ====
`default_nettype none

package bridgePkg;

        ////////////////////
        // Bus geometry
        ////////////////////
        localparam int AddrWidth = 32;
        localparam int DataWidth = 32;

        // Select vector width and upper bound for NumSlaves
        localparam int MaxSlaves = 4;

        // Peripheral index field, wide enough to hit unmapped regions
        localparam int RegionBits = 4;

        ////////////////////
        // AHB encodings
        ////////////////////
        typedef enum logic [2:0]
        {
                SizeByte = 3'b000,
                SizeHalf = 3'b001,
                SizeWord = 3'b010
        } hsize_e;

        typedef enum logic [1:0]
        {
                TransIdle   = 2'b00,
                TransBusy   = 2'b01,
                TransNonseq = 2'b10,
                TransSeq    = 2'b11
        } htrans_e;

        // Address phase as held for the APB side
        typedef struct packed
        {
                logic [AddrWidth-1:0] addr;
                hsize_e               size;
                logic                 write;
                logic                 mapped;
                logic [MaxSlaves-1:0] slaveSel;
        } ahbReq_t;

        // Same word seen as byte lanes or halfword lanes
        typedef union packed
        {
                logic [DataWidth/8-1:0][7:0]   bytes;
                logic [DataWidth/16-1:0][15:0] halves;
        } laneWord_u;

endpackage

`default_nettype wire

// ==== design/ahbCapture.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahbCapture #(
        parameter int NumSlaves = 4,
        parameter int RegionLsb = 12
) (
        input  wire logic                           Hclk,
        input  wire logic                           Hresetn,
        input  wire logic                           Hsel,
        input  wire logic [bridgePkg::AddrWidth-1:0] Haddr,
        input  wire bridgePkg::htrans_e             Htrans,
        input  wire bridgePkg::hsize_e              Hsize,
        input  wire logic                           Hwrite,
        input  wire logic [bridgePkg::DataWidth-1:0] Hwdata,
        input  wire logic                           Hreadyout,
        output bridgePkg::ahbReq_t                  req,
        output logic                                reqValid,
        output logic [bridgePkg::DataWidth-1:0]     wdataReg
);
        import bridgePkg::*;

        logic [RegionBits-1:0] index;
        logic [MaxSlaves-1:0]  selNext;
        logic                  mappedNext;
        logic                  dataPhase;

        // NONSEQ or SEQ while the bridge is free
        assign reqValid = Hsel && Hreadyout && (Htrans == TransNonseq || Htrans == TransSeq);

        assign index      = Haddr[RegionLsb +: RegionBits];
        assign mappedNext = int'(index) < NumSlaves;

        // One-hot select, left empty for unmapped regions
        always_comb
        begin
                selNext = '0;
                for (int i = 0; i < NumSlaves; i++)
                begin
                        if (int'(index) == i)
                        begin
                                selNext[i] = 1'b1;
                        end
                end
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        req       <= '0;
                        dataPhase <= 1'b0;
                end
                else
                begin
                        dataPhase <= reqValid;
                        if (reqValid)
                        begin
                                req.addr     <= Haddr;
                                req.size     <= Hsize;
                                req.write    <= Hwrite;
                                req.mapped   <= mappedNext;
                                req.slaveSel <= selNext;
                        end
                end
        end

        // Write data follows its address by one cycle
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        wdataReg <= '0;
                end
                else if (dataPhase && req.write)
                begin
                        wdataReg <= Hwdata;
                end
        end

endmodule

`default_nettype wire

// ==== design/bridgeFsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridgeFsm (
        input  wire logic Hclk,
        input  wire logic Hresetn,
        input  wire logic reqValid,
        input  wire logic reqWrite,
        output logic      Hreadyout,
        output logic      Penable,
        output logic      Pwrite,
        output logic      selEnable,
        output logic      readLatch
);
        typedef enum logic [1:0]
        {
                StIdle   = 2'b00,
                StWait   = 2'b01,
                StSetup  = 2'b10,
                StAccess = 2'b11
        } state_e;

        state_e state;
        state_e stateNext;

        ////////////////////
        // Next state
        ////////////////////
        always_comb
        begin
                stateNext = state;
                case (state)
                        StIdle:
                        begin
                                if (reqValid)
                                begin
                                        // Writes need one cycle for Hwdata
                                        stateNext = reqWrite ? StWait : StSetup;
                                end
                        end
                        StWait:
                        begin
                                stateNext = StSetup;
                        end
                        StSetup:
                        begin
                                stateNext = StAccess;
                        end
                        StAccess:
                        begin
                                // Fixed two-cycle APB access
                                stateNext = StIdle;
                        end
                        default:
                        begin
                                stateNext = StIdle;
                        end
                endcase
        end

        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        state  <= StIdle;
                        Pwrite <= 1'b0;
                end
                else
                begin
                        state <= stateNext;
                        if (state == StIdle && reqValid)
                        begin
                                Pwrite <= reqWrite;
                        end
                        else if (state == StAccess)
                        begin
                                Pwrite <= 1'b0;
                        end
                end
        end

        ////////////////////
        // Outputs
        ////////////////////
        assign Hreadyout = (state == StIdle);
        assign Penable   = (state == StAccess);
        assign selEnable = (state == StSetup) || (state == StAccess);

        // Prdata is sampled at the end of this cycle
        assign readLatch = (state == StAccess) && !Pwrite;

endmodule

`default_nettype wire

// ==== design/laneSteer.sv ====
`timescale 1ns/100ps
`default_nettype none

module laneSteer (
        input  wire logic [bridgePkg::DataWidth-1:0] word,
        input  wire bridgePkg::hsize_e               size,
        input  wire logic [1:0]                      offset,
        output logic [bridgePkg::DataWidth-1:0]      lane
);
        import bridgePkg::*;

        laneWord_u view;

        assign view = word;

        // Little endian, addressed lane lands at bit 0
        always_comb
        begin
                lane = '0;
                case (size)
                        SizeByte:
                        begin
                                lane = DataWidth'(view.bytes[offset]);
                        end
                        SizeHalf:
                        begin
                                if (!offset[0])
                                begin
                                        lane = DataWidth'(view.halves[offset[1]]);
                                end
                        end
                        SizeWord:
                        begin
                                if (offset == 2'b00)
                                begin
                                        lane = word;
                                end
                        end
                        default:
                        begin
                                // Wider than the bus
                                lane = '0;
                        end
                endcase
        end

endmodule

`default_nettype wire

// ==== design/ahbApbBridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module ahbApbBridge #(
        parameter int NumSlaves = 4,
        parameter int RegionLsb = 12
) (
        input  wire logic                           Hclk,
        input  wire logic                           Hresetn,
        // AHB-Lite slave side
        input  wire logic                           Hsel,
        input  wire logic [bridgePkg::AddrWidth-1:0] Haddr,
        input  wire bridgePkg::htrans_e             Htrans,
        input  wire bridgePkg::hsize_e              Hsize,
        input  wire logic                           Hwrite,
        input  wire logic [bridgePkg::DataWidth-1:0] Hwdata,
        output logic                                Hreadyout,
        output logic [bridgePkg::DataWidth-1:0]     Hrdata,
        // APB master side
        output logic [bridgePkg::AddrWidth-1:0]     Paddr,
        output logic [bridgePkg::MaxSlaves-1:0]     Psel,
        output logic                                Penable,
        output logic                                Pwrite,
        output logic [bridgePkg::DataWidth-1:0]     Pwdata,
        input  wire logic [bridgePkg::DataWidth-1:0] Prdata
);
        import bridgePkg::*;

        ahbReq_t              req;
        logic                 reqValid;
        logic [DataWidth-1:0] wdataReg;
        logic                 selEnable;
        logic                 readLatch;
        logic [DataWidth-1:0] readLane;

        ahbCapture #(
                .NumSlaves(NumSlaves),
                .RegionLsb(RegionLsb)
        ) ahbCapture_i (
                .Hclk     (Hclk),
                .Hresetn  (Hresetn),
                .Hsel     (Hsel),
                .Haddr    (Haddr),
                .Htrans   (Htrans),
                .Hsize    (Hsize),
                .Hwrite   (Hwrite),
                .Hwdata   (Hwdata),
                .Hreadyout(Hreadyout),
                .req      (req),
                .reqValid (reqValid),
                .wdataReg (wdataReg)
        );

        // Direction is needed at the acceptance edge itself
        bridgeFsm bridgeFsm_i (
                .Hclk     (Hclk),
                .Hresetn  (Hresetn),
                .reqValid (reqValid),
                .reqWrite (Hwrite),
                .Hreadyout(Hreadyout),
                .Penable  (Penable),
                .Pwrite   (Pwrite),
                .selEnable(selEnable),
                .readLatch(readLatch)
        );

        laneSteer writeSteer (
                .word  (wdataReg),
                .size  (req.size),
                .offset(req.addr[1:0]),
                .lane  (Pwdata)
        );

        laneSteer readSteer (
                .word  (Prdata),
                .size  (req.size),
                .offset(req.addr[1:0]),
                .lane  (readLane)
        );

        assign Paddr = req.addr;
        assign Psel  = (selEnable && req.mapped) ? req.slaveSel : '0;

        // Unmapped reads complete with zero data
        always_ff @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        Hrdata <= '0;
                end
                else if (readLatch)
                begin
                        Hrdata <= req.mapped ? readLane : '0;
                end
        end

endmodule

`default_nettype wire

// ==== testbench/bridge_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridgeProps (
        input wire logic                           Hclk,
        input wire logic                           Hresetn,
        input wire logic [bridgePkg::MaxSlaves-1:0] Psel,
        input wire logic                           Penable,
        input wire logic                           Pwrite,
        input wire logic [bridgePkg::AddrWidth-1:0] Paddr,
        input wire logic                           Hreadyout,
        input wire logic                           selEnable,
        input wire logic                           reqValid
);
        ////////////////////
        // APB protocol
        ////////////////////
        penableAfterSetup: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Penable && Psel != '0) |-> $past(Psel != '0 && !Penable))
                else $error("Penable rose without a setup cycle");

        // Address and direction held through setup and access
        stableWhileSelected: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Psel != '0 && $past(Psel != '0)) |-> ($stable(Paddr) && $stable(Pwrite)))
                else $error("Paddr or Pwrite changed while selected");

        readyWhenIdle: assert property (@(posedge Hclk) disable iff (!Hresetn)
                (Psel == '0 && !selEnable && !$past(reqValid)) |-> Hreadyout)
                else $error("Hreadyout low while the bridge is idle");

endmodule

bind ahbApbBridge bridgeProps bridgeProps_i (
        .Hclk     (Hclk),
        .Hresetn  (Hresetn),
        .Psel     (Psel),
        .Penable  (Penable),
        .Pwrite   (Pwrite),
        .Paddr    (Paddr),
        .Hreadyout(Hreadyout),
        .selEnable(selEnable),
        .reqValid (reqValid)
);

`default_nettype wire

// ==== testbench/bridgeTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module bridgeTb;
        import bridgePkg::*;

        localparam int          ResetCycles = 10;
        localparam int          RegionLsb   = 12;
        localparam logic [31:0] LfsrSeed    = 32'h9e15_8f0d;
        localparam logic [31:0] LfsrTaps    = 32'hd000_0001;

        // One transfer and what the bus should show for it
        typedef struct packed
        {
                logic                 write;
                logic [31:0]          addr;
                hsize_e               size;
                logic [31:0]          data;
                logic [MaxSlaves-1:0] expSel;
                logic [31:0]          expPwdata;
                logic [31:0]          expHrdata;
        } stim_t;

        logic                 Hclk = 1'b0;
        logic                 Hresetn;
        logic                 Hsel;
        logic [31:0]          Haddr;
        htrans_e              Htrans;
        hsize_e               Hsize;
        logic                 Hwrite;
        logic [31:0]          Hwdata;
        logic                 Hreadyout;
        logic [31:0]          Hrdata;
        logic [31:0]          Paddr;
        logic [MaxSlaves-1:0] Psel;
        logic                 Penable;
        logic                 Pwrite;
        logic [31:0]          Pwdata;
        logic [31:0]          Prdata;

        logic [31:0] slaveRegs [MaxSlaves];
        logic [31:0] modelRegs [MaxSlaves];
        logic [31:0] lfsrState;
        stim_t       stimTable [$];
        int          cycleCount;
        int          timeoutLimit;
        int          errorCount;

        ahbApbBridge ahbApbBridge_i (.*);

        always #2 Hclk = ~Hclk;

        ////////////////////
        // APB slave model
        ////////////////////
        always @(posedge Hclk or negedge Hresetn)
        begin
                if (!Hresetn)
                begin
                        for (int i = 0; i < MaxSlaves; i++)
                        begin
                                slaveRegs[i] <= '0;
                        end
                end
                else if (Penable && Pwrite)
                begin
                        for (int i = 0; i < MaxSlaves; i++)
                        begin
                                if (Psel[i])
                                begin
                                        slaveRegs[i] <= Pwdata;
                                end
                        end
                end
        end

        always_comb
        begin
                Prdata = '0;
                for (int i = 0; i < MaxSlaves; i++)
                begin
                        if (Psel[i])
                        begin
                                Prdata = slaveRegs[i];
                        end
                end
        end

        always @(posedge Hclk)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= timeoutLimit)
                begin
                        $display("Timeout: transfers did not finish within %0d cycles",
                                 timeoutLimit);
                        $display("Finished with errors");
                        $fatal(1, "Simulation timed out");
                end
        end

        ////////////////////
        // Reference model
        ////////////////////
        function automatic logic [31:0] lfsrStep(input logic [31:0] state);
                return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
        endfunction

        function automatic logic [31:0] randomWord();
                logic [31:0] value;
                value = '0;
                for (int i = 0; i < 32; i++)
                begin
                        value     = {value[30:0], lfsrState[0]};
                        lfsrState = lfsrStep(lfsrState);
                end
                return value;
        endfunction

        // Addressed lane shifted down to bit 0
        function automatic logic [31:0] refSteer(input logic [31:0] word, input hsize_e size,
                                                 input logic [1:0] offset);
                logic [31:0] shifted;
                shifted = word >> (8 * offset);
                case (size)
                        SizeByte: return shifted & 32'h0000_00ff;
                        SizeHalf: return offset[0] ? 32'h0 : (shifted & 32'h0000_ffff);
                        SizeWord: return (offset == 2'b00) ? word : 32'h0;
                        default:  return 32'h0;
                endcase
        endfunction

        function automatic logic [31:0] slaveAddr(input int slave, input int offset);
                return (32'(slave) << RegionLsb) | 32'h40 | 32'(offset);
        endfunction

        function automatic void addEntry(input logic write, input logic [31:0] addr,
                                         input hsize_e size, input logic [31:0] data);
                stim_t      s;
                logic [3:0] index;
                logic       mapped;
                index       = addr[RegionLsb +: 4];
                mapped      = int'(index) < MaxSlaves;
                s.write     = write;
                s.addr      = addr;
                s.size      = size;
                s.data      = data;
                s.expSel    = mapped ? MaxSlaves'(32'd1 << index) : '0;
                s.expPwdata = write ? refSteer(data, size, addr[1:0]) : '0;
                s.expHrdata = '0;
                if (mapped && write)
                begin
                        modelRegs[index[1:0]] = s.expPwdata;
                end
                else if (mapped)
                begin
                        s.expHrdata = refSteer(modelRegs[index[1:0]], size, addr[1:0]);
                end
                stimTable.push_back(s);
        endfunction

        task automatic buildTable();
                for (int s = 0; s < MaxSlaves; s++)
                begin
                        modelRegs[s] = '0;
                end
                for (int s = 0; s < MaxSlaves; s++)
                begin
                        addEntry(1'b1, slaveAddr(s, 0), SizeWord, randomWord());
                end
                for (int s = 0; s < MaxSlaves; s++)
                begin
                        addEntry(1'b0, slaveAddr(s, 0), SizeWord, '0);
                end
                // Sub-word reads, odd halfword offsets are misaligned
                for (int off = 0; off < 4; off++)
                begin
                        addEntry(1'b0, slaveAddr(off, off), SizeByte, '0);
                        addEntry(1'b0, slaveAddr(3 - off, off), SizeHalf, '0);
                end
                for (int off = 0; off < 4; off++)
                begin
                        addEntry(1'b1, slaveAddr(off, off), SizeByte, randomWord());
                        addEntry(1'b1, slaveAddr(3 - off, off), SizeHalf, randomWord());
                end
                // Slave 1 now holds a steered halfword
                addEntry(1'b0, slaveAddr(1, 0), SizeWord, '0);
                // Unmapped regions
                addEntry(1'b1, slaveAddr(4, 0), SizeWord, randomWord());
                addEntry(1'b0, slaveAddr(9, 2), SizeHalf, '0);
        endtask

        ////////////////////
        // Driver and checks
        ////////////////////
        task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                                  input string what);
                if (actual !== expected)
                begin
                        errorCount++;
                        $display("FAILED at %0t: %s is %h, expected %h",
                                 $time, what, actual, expected);
                        $display("Finished with errors");
                        $fatal(1, "Stopping at the first mismatch");
                end
        endtask

        task automatic runTransfer(input stim_t s);
                int lowCycles;
                int accessCycles;
                lowCycles    = 0;
                accessCycles = 0;
                @(posedge Hclk);
                #1;
                Hsel   = 1'b1;
                Haddr  = s.addr;
                Htrans = TransNonseq;
                Hsize  = s.size;
                Hwrite = s.write;
                @(negedge Hclk);
                checkValue(32'(Hreadyout), 32'd1, "Hreadyout before acceptance");
                @(posedge Hclk);
                #1;
                // Data phase
                Hsel   = 1'b0;
                Htrans = TransIdle;
                Hwdata = s.data;
                @(negedge Hclk);
                while (!Hreadyout)
                begin
                        lowCycles++;
                        if (Penable)
                        begin
                                accessCycles++;
                                checkValue(32'(Psel), 32'(s.expSel), "Psel");
                                checkValue(32'(Pwrite), 32'(s.write), "Pwrite");
                                checkValue(Paddr, s.addr, "Paddr");
                                if (s.write)
                                begin
                                        checkValue(Pwdata, s.expPwdata, "Pwdata");
                                end
                        end
                        @(negedge Hclk);
                end
                checkValue(32'(lowCycles), s.write ? 32'd3 : 32'd2, "Hreadyout low cycles");
                checkValue(32'(accessCycles), 32'd1, "APB access cycles");
                checkValue(32'(Psel), 32'd0, "Psel after transfer");
                checkValue(32'(Penable), 32'd0, "Penable after transfer");
                if (!s.write)
                begin
                        checkValue(Hrdata, s.expHrdata, "Hrdata");
                end
        endtask

        initial
        begin
                Hresetn    = 1'b0;
                Hsel       = 1'b0;
                Haddr      = '0;
                Htrans     = TransIdle;
                Hsize      = SizeWord;
                Hwrite     = 1'b0;
                Hwdata     = '0;
                errorCount = 0;
                lfsrState  = LfsrSeed;
                buildTable();
                timeoutLimit = 20 * stimTable.size() + ResetCycles;
                repeat (ResetCycles - 1) @(posedge Hclk);
                @(negedge Hclk);
                checkValue(32'(Hreadyout), 32'd1, "Hreadyout in reset");
                checkValue(32'(Psel), 32'd0, "Psel in reset");
                checkValue(32'(Penable), 32'd0, "Penable in reset");
                checkValue(32'(Pwrite), 32'd0, "Pwrite in reset");
                checkValue(Paddr, 32'd0, "Paddr in reset");
                checkValue(Pwdata, 32'd0, "Pwdata in reset");
                checkValue(Hrdata, 32'd0, "Hrdata in reset");
                @(posedge Hclk);
                #1;
                Hresetn = 1'b1;
                foreach (stimTable[i])
                begin
                        runTransfer(stimTable[i]);
                end
                if (errorCount == 0)
                begin
                        $display("Finished with no errors");
                end
                else
                begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== compile.f ====
design/bridgePkg.sv
design/ahbCapture.sv
design/bridgeFsm.sv
design/laneSteer.sv
design/ahbApbBridge.sv
testbench/bridge_props.sv
testbench/bridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module bridgeTb -Mdir obj_dir
output=$(./obj_dir/VbridgeTb || true)
echo "$output"
if grep -qx "Finished with no errors" <<< "$output"; then
    exit 0
fi
exit 1
